/* design/axi_sram_pkg.sv */
package axi_sram_pkg;

    // bus geometry.
    localparam int addr_bits = 32;
    localparam int data_bits = 32;
    localparam int strb_bits = data_bits / 8;
    localparam int id_bits   = 4;
    localparam int len_bits  = 4;       // beats per burst are len + 1.

    // the word address is taken from address bits 15 down to 2.
    localparam int sram_addr_bits = 14;
    localparam int sram_words     = 1 << sram_addr_bits;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_t;

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } burst_t;

    typedef struct packed {
        logic [id_bits-1:0]   id;
        logic [addr_bits-1:0] addr;
        logic [len_bits-1:0]  len;
        burst_t               burst;
    } aw_chan_t;

    typedef struct packed {
        logic [id_bits-1:0]   id;
        logic [addr_bits-1:0] addr;
        logic [len_bits-1:0]  len;
        burst_t               burst;
    } ar_chan_t;

    typedef struct packed {
        logic [data_bits-1:0] data;
        logic [strb_bits-1:0] strb;
        logic                 last;
    } w_chan_t;

    typedef struct packed {
        logic [id_bits-1:0] id;
        resp_t              resp;
    } b_chan_t;

    typedef struct packed {
        logic [id_bits-1:0]   id;
        logic [data_bits-1:0] data;
        resp_t                resp;
        logic                 last;
    } r_chan_t;

    typedef enum logic [1:0] {
        st_idle  = 2'b00,
        st_read  = 2'b01,
        st_write = 2'b10
    } wrapper_state_t;

endpackage

/* design/sram_macro.sv */
`timescale 1ns/1ps

module sram_macro (
    input  logic                                   clk,
    input  logic                                   cs,
    input  logic                                   oe,
    input  logic [axi_sram_pkg::strb_bits-1:0]      web,
    input  logic [axi_sram_pkg::sram_addr_bits-1:0] addr,
    input  logic [axi_sram_pkg::data_bits-1:0]      wdata,
    output logic [axi_sram_pkg::data_bits-1:0]      rdata
);
    import axi_sram_pkg::*;

    // behavioral stand-in for the memory macro, cleared at start.
    logic [data_bits-1:0] mem [sram_words] = '{default: '0};

    // each byte lane has its own active-low write enable.
    always_ff @(posedge clk) begin
        if (cs) begin
            for (int i = 0; i < strb_bits; i++) begin
                if (!web[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // the read is registered, so data shows up after the edge that took the address.
    always_ff @(posedge clk) begin
        if (cs && oe) begin
            rdata <= mem[addr];
        end
    end

endmodule

/* design/axi_sram_wrapper.sv */
`timescale 1ns/1ps

module axi_sram_wrapper (
    input  logic                   clk,
    input  logic                   rstn,
    input  axi_sram_pkg::aw_chan_t aw,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  axi_sram_pkg::w_chan_t  w,
    input  logic                   w_valid,
    output logic                   w_ready,
    output axi_sram_pkg::b_chan_t  b,
    output logic                   b_valid,
    input  logic                   b_ready,
    input  axi_sram_pkg::ar_chan_t ar,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    output axi_sram_pkg::r_chan_t  r,
    output logic                   r_valid,
    input  logic                   r_ready
);
    import axi_sram_pkg::*;

    wrapper_state_t state;
    wrapper_state_t next_state;

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;
    logic accept;       // a new AW or AR may be taken this cycle.

    logic [sram_addr_bits-1:0] addr_q;
    logic [id_bits-1:0]        id_q;
    logic [len_bits-1:0]       len_q;
    logic [len_bits-1:0]       beat_cnt;
    logic                      b_pend;

    logic [sram_addr_bits-1:0] sram_addr;
    logic [data_bits-1:0]      sram_wdata;
    logic [data_bits-1:0]      sram_rdata;
    logic [strb_bits-1:0]      sram_web;
    logic                      sram_cs;
    logic                      sram_oe;

    assign aw_hs = aw_valid & aw_ready;
    assign w_hs  = w_valid & w_ready;
    assign b_hs  = b_valid & b_ready;
    assign ar_hs = ar_valid & ar_ready;
    assign r_hs  = r_valid & r_ready;

    // the next burst can start on the cycle that finishes the current one.
    always_comb begin
        case (state)
            st_read:  accept = r_hs & r.last;
            st_write: accept = b_hs;
            default:  accept = 1'b1;
        endcase
    end

    assign aw_ready = accept;
    assign ar_ready = accept & ~aw_valid;    // a write offered at the same time wins.
    assign w_ready  = (state == st_write) & ~b_pend;
    assign b_valid  = (state == st_write) & b_pend;
    assign r_valid  = (state == st_read);

    assign b.id   = id_q;
    assign b.resp = resp_okay;

    assign r.id   = id_q;
    assign r.data = sram_rdata;
    assign r.resp = resp_okay;
    assign r.last = (beat_cnt == len_q);

    always_comb begin
        next_state = state;
        if (aw_hs) begin
            next_state = st_write;
        end else if (ar_hs) begin
            next_state = st_read;
        end else if (accept) begin
            next_state = st_idle;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // every burst type is walked as incr, one word per beat.
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            addr_q <= aw.addr[sram_addr_bits+1:2];
            id_q   <= aw.id;
            len_q  <= aw.len;
        end else if (ar_hs) begin
            addr_q <= ar.addr[sram_addr_bits+1:2];
            id_q   <= ar.id;
            len_q  <= ar.len;
        end else if (r_hs || w_hs) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
            b_pend   <= 1'b0;
        end else begin
            if (aw_hs || ar_hs) begin
                beat_cnt <= '0;
            end else if (r_hs || w_hs) begin
                beat_cnt <= beat_cnt + 1'b1;
            end

            if (b_hs) begin
                b_pend <= 1'b0;
            end else if (w_hs && w.last) begin
                b_pend <= 1'b1;        // the last beat is in, so B goes out next.
            end
        end
    end

    // look one word ahead when a beat is taken, so the next beat is ready a cycle later.
    always_comb begin
        if (ar_hs || state == st_idle) begin
            sram_addr = ar.addr[sram_addr_bits+1:2];
        end else if (r_hs) begin
            sram_addr = addr_q + 1'b1;
        end else begin
            sram_addr = addr_q;  // re-reading the same word keeps r steady under back-pressure.
        end
    end

    assign sram_oe    = (state == st_read) | ar_hs;
    assign sram_cs    = sram_oe | w_hs;
    assign sram_web   = w_hs ? ~w.strb : '1;
    assign sram_wdata = w.data;

    sram_macro u_sram (
        .clk   (clk),
        .cs    (sram_cs),
        .oe    (sram_oe),
        .web   (sram_web),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

endmodule

/* design/axi_sram_top.sv */
`timescale 1ns/1ps

module axi_sram_top (
    input  logic                   clk,
    input  logic                   rstn,

    input  axi_sram_pkg::aw_chan_t aw,
    input  logic                   aw_valid,
    output logic                   aw_ready,

    input  axi_sram_pkg::w_chan_t  w,
    input  logic                   w_valid,
    output logic                   w_ready,

    output axi_sram_pkg::b_chan_t  b,
    output logic                   b_valid,
    input  logic                   b_ready,

    input  axi_sram_pkg::ar_chan_t ar,
    input  logic                   ar_valid,
    output logic                   ar_ready,

    output axi_sram_pkg::r_chan_t  r,
    output logic                   r_valid,
    input  logic                   r_ready
);

    // all five channels go straight to the slave, no extra pipeline stage.
    axi_sram_wrapper u_wrapper (
        .clk      (clk),
        .rstn     (rstn),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

endmodule

/* verification/axi_sram_checker.sv */
`timescale 1ns/1ps

module axi_sram_checker (
    input logic                  clk,
    input logic                  rstn,
    input axi_sram_pkg::b_chan_t b,
    input logic                  b_valid,
    input logic                  b_ready,
    input axi_sram_pkg::r_chan_t r,
    input logic                  r_valid,
    input logic                  r_ready,
    input logic                  w_ready
);
    import axi_sram_pkg::*;

    // a read beat that is not taken stays on the bus unchanged.
    r_hold: assert property (@(posedge clk) disable iff (!rstn)
        (r_valid && !r_ready) |=> (r_valid && $stable(r)))
        else $error("r changed or dropped while r_ready was low");

    b_hold: assert property (@(posedge clk) disable iff (!rstn)
        (b_valid && !b_ready) |=> (b_valid && $stable(b)))
        else $error("b changed or dropped while b_ready was low");

    // the slave is never in a read and a write burst at once.
    one_burst: assert property (@(posedge clk) disable iff (!rstn)
        !(w_ready && r_valid))
        else $error("w_ready and r_valid were high together");

endmodule

/* verification/axi_sram_tb.sv */
`timescale 1ns/1ps

module axi_sram_tb;
    import axi_sram_pkg::*;

    // about 400 bus cycles with random stalls, so 20 us leaves a wide margin.
    localparam int watchdog_ns = 20000;

    logic     clk;
    logic     rstn;
    aw_chan_t aw;
    logic     aw_valid;
    logic     aw_ready;
    w_chan_t  w;
    logic     w_valid;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
    logic     r_ready;

    integer seed = 49;
    logic [data_bits-1:0] ref_mem [sram_words] = '{default: '0};  // expected SRAM contents.

    axi_sram_top uut (
        .clk      (clk),
        .rstn     (rstn),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    bind axi_sram_wrapper axi_sram_checker u_checker (
        .clk     (clk),
        .rstn    (rstn),
        .b       (b),
        .b_valid (b_valid),
        .b_ready (b_ready),
        .r       (r),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .w_ready (w_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Some tests failed");
        $fatal(1, "watchdog expired before the tests finished");
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // inputs change 1 ns after the rising edge, outputs are sampled at the falling edge.
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_aw(input logic [id_bits-1:0] id, input logic [addr_bits-1:0] addr,
                           input logic [len_bits-1:0] len);
        aw.id    = id;
        aw.addr  = addr;
        aw.len   = len;
        aw.burst = burst_incr;
        aw_valid = 1'b1;
        @(negedge clk);
        while (!aw_ready) @(negedge clk);
        next_cycle();
        aw_valid = 1'b0;
    endtask

    task automatic send_w_beats(input logic [addr_bits-1:0] addr, input logic [len_bits-1:0] len,
                                input logic [data_bits-1:0] data [$],
                                input logic [strb_bits-1:0] strb [$]);
        logic [sram_addr_bits-1:0] word;
        word = addr[sram_addr_bits+1:2];
        for (int i = 0; i <= len; i++) begin
            w.data  = data[i];
            w.strb  = strb[i];
            w.last  = (i == len);
            w_valid = 1'b1;
            @(negedge clk);
            while (!w_ready) @(negedge clk);
            for (int k = 0; k < strb_bits; k++) begin
                if (strb[i][k]) begin
                    ref_mem[word][8*k +: 8] = data[i][8*k +: 8];  // only enabled lanes change.
                end
            end
            word = word + 1'b1;
            next_cycle();
        end
        w_valid = 1'b0;
        w.last  = 1'b0;
    endtask

    task automatic wait_b(input logic [id_bits-1:0] id);
        @(negedge clk);
        while (!b_valid) @(negedge clk);
        next_cycle();  // make the response wait one cycle.
        b_ready = 1'b1;
        @(negedge clk);
        check("b_valid", b_valid, 1);
        check("b.id", b.id, id);
        check("b.resp", b.resp, resp_okay);
        next_cycle();
        b_ready = 1'b0;
    endtask

    task automatic send_ar(input logic [id_bits-1:0] id, input logic [addr_bits-1:0] addr,
                           input logic [len_bits-1:0] len);
        ar.id    = id;
        ar.addr  = addr;
        ar.len   = len;
        ar.burst = burst_incr;
        ar_valid = 1'b1;
        @(negedge clk);
        while (!ar_ready) @(negedge clk);
        next_cycle();
        ar_valid = 1'b0;
    endtask

    task automatic collect_r(input logic [id_bits-1:0] id, input logic [addr_bits-1:0] addr,
                             input logic [len_bits-1:0] len, input logic random_ready);
        logic [sram_addr_bits-1:0] word;
        logic [31:0]               rnd;
        int                        beat;
        word = addr[sram_addr_bits+1:2];
        beat = 0;
        while (beat <= len) begin
            rnd     = $random(seed);
            r_ready = random_ready ? rnd[0] : 1'b1;
            @(negedge clk);
            if (!random_ready) begin
                check("r_valid", r_valid, 1);  // one beat per cycle when never stalled.
            end
            if (r_valid && r_ready) begin
                check("r.id", r.id, id);
                check("r.data", r.data, ref_mem[word]);
                check("r.resp", r.resp, resp_okay);
                check("r.last", r.last, (beat == len));
                word = word + 1'b1;
                beat++;
            end
            next_cycle();
        end
        r_ready = 1'b0;
        @(negedge clk);
        check("r_valid after last beat", r_valid, 0);
        next_cycle();
    endtask

    task automatic axi_write(input logic [id_bits-1:0] id, input logic [addr_bits-1:0] addr,
                             input logic [len_bits-1:0] len,
                             input logic [data_bits-1:0] data [$],
                             input logic [strb_bits-1:0] strb [$]);
        send_aw(id, addr, len);
        send_w_beats(addr, len, data, strb);
        wait_b(id);
    endtask

    task automatic axi_read(input logic [id_bits-1:0] id, input logic [addr_bits-1:0] addr,
                            input logic [len_bits-1:0] len, input logic random_ready);
        send_ar(id, addr, len);
        collect_r(id, addr, len, random_ready);
    endtask

    task automatic test_reset_idle();
        @(negedge clk);
        check("b_valid", b_valid, 0);
        check("r_valid", r_valid, 0);
        check("w_ready", w_ready, 0);
        check("aw_ready", aw_ready, 1);
        check("ar_ready", ar_ready, 1);
        next_cycle();
    endtask

    task automatic test_single_beat();
        logic [data_bits-1:0] data [$];
        logic [strb_bits-1:0] strb [$];
        data.push_back(32'hcafe_0001);
        strb.push_back(4'b1111);
        axi_write(4'h3, 32'h0000_0040, 4'd0, data, strb);
        axi_read(4'h5, 32'h0000_0040, 4'd0, 1'b0);
    endtask

    task automatic test_burst16();
        logic [data_bits-1:0] data [$];
        logic [strb_bits-1:0] strb [$];
        for (int i = 0; i < 16; i++) begin
            data.push_back($random(seed));
            strb.push_back(4'b1111);
        end
        axi_write(4'ha, 32'h0000_0100, 4'd15, data, strb);
        for (int k = 0; k < 4; k++) begin
            axi_read(4'h1, 32'h0000_0100 + 16 * k, 4'd3, 1'b0);  // four words per read.
        end
        axi_read(4'h2, 32'h0000_0100, 4'd15, 1'b0);
    endtask

    task automatic test_byte_lanes();
        logic [data_bits-1:0] data [$];
        logic [strb_bits-1:0] strb [$];
        logic [strb_bits-1:0] lanes [3];
        lanes[0] = 4'b0001;
        lanes[1] = 4'b1100;
        lanes[2] = 4'b1010;
        data.push_back(32'h1122_3344);
        strb.push_back(4'b1111);
        axi_write(4'h4, 32'h0000_0200, 4'd0, data, strb);
        for (int i = 0; i < 3; i++) begin
            data.delete();
            strb.delete();
            data.push_back($random(seed));
            strb.push_back(lanes[i]);
            axi_write(4'h4, 32'h0000_0200, 4'd0, data, strb);
            axi_read(4'h4, 32'h0000_0200, 4'd0, 1'b0);
        end
        // the same strobes inside one burst.
        data.delete();
        strb.delete();
        for (int i = 0; i < 3; i++) begin
            data.push_back($random(seed));
            strb.push_back(lanes[i]);
        end
        axi_write(4'hc, 32'h0000_0300, 4'd2, data, strb);
        axi_read(4'hd, 32'h0000_0300, 4'd2, 1'b0);
    endtask

    task automatic test_read_backpressure();
        logic [data_bits-1:0] data [$];
        logic [strb_bits-1:0] strb [$];
        for (int i = 0; i < 8; i++) begin
            data.push_back($random(seed));
            strb.push_back(4'b1111);
        end
        axi_write(4'he, 32'h0000_0a00, 4'd7, data, strb);
        axi_read(4'h6, 32'h0000_0a00, 4'd7, 1'b1);
        axi_read(4'h7, 32'h0000_0100, 4'd15, 1'b1);
    endtask

    task automatic test_write_priority();
        logic [data_bits-1:0] data [$];
        logic [strb_bits-1:0] strb [$];
        data.push_back(32'h5a5a_f00d);
        strb.push_back(4'b1111);
        aw.id    = 4'h8;
        aw.addr  = 32'h0000_0400;
        aw.len   = 4'd0;
        aw.burst = burst_incr;
        ar.id    = 4'h9;
        ar.addr  = 32'h0000_0400;
        ar.len   = 4'd0;
        ar.burst = burst_incr;
        aw_valid = 1'b1;
        ar_valid = 1'b1;
        @(negedge clk);
        check("aw_ready", aw_ready, 1);
        check("ar_ready", ar_ready, 0);
        next_cycle();
        aw_valid = 1'b0;
        send_w_beats(32'h0000_0400, 4'd0, data, strb);
        check("r_valid during write", r_valid, 0);
        wait_b(4'h8);
        check("r_valid after write", r_valid, 1);  // the read was taken with the B handshake.
        ar_valid = 1'b0;
        collect_r(4'h9, 32'h0000_0400, 4'd0, 1'b0);
    endtask

    initial begin
        rstn     = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        test_reset_idle();
        test_single_beat();
        test_burst16();
        test_byte_lanes();
        test_read_backpressure();
        test_write_priority();

        $display("All tests passed");
        $finish;
    end

endmodule

/* verilog.f */
design/axi_sram_pkg.sv
design/sram_macro.sv
design/axi_sram_wrapper.sv
design/axi_sram_top.sv
verification/axi_sram_checker.sv
verification/axi_sram_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f verilog.f \
        --top-module axi_sram_tb -o axi_sram_sim \
    && ./obj_dir/axi_sram_sim \
    || { echo "simulation did not complete successfully"; exit 1; }
